//--- bench/fm_model.svh
`ifndef FM_MODEL_SVH
`define FM_MODEL_SVH

// Channel c runs a fixed step above the row's base fnum
function automatic logic [10:0] ch_fnum(input logic [10:0] base, input int c);
	return base + 11'(c * 64);
endfunction

// Octave scales fnum, result halved
function automatic int phase_inc(input logic [10:0] f, input int blk);
	return (int'(f) * (1 << blk)) / 2;
endfunction

// Triangle over the top ten phase bits
function automatic int tri_value(input int p);
	if (p < 256)
		return p;
	else if (p < 768)
		return 511 - p;
	else
		return p - 1024;
endfunction

// Channel output at its k-th keyed slot
function automatic int chan_value(input logic [10:0] f, input int blk, input int tl,
	input int k);
	int ph;
	ph = (k * phase_inc(f, blk)) % (1 << 20);
	return tri_value(ph >> 10) >>> tl;
endfunction

// One stereo side, keyed channels routed to it
function automatic int sample_sum(input logic [10:0] base, input int blk, input int tl,
	input logic [3:0] pan, input logic [3:0] key, input int k);
	int s;
	s = 0;
	for (int c = 0; c < 4; c++) begin
		if (pan[c] && key[c])
			s += chan_value(ch_fnum(base, c), blk, tl, k);
	end
	return s;
endfunction

`endif

//--- bench/fm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fm_tb;

	typedef struct packed {
		logic [2:0] block;
		logic [2:0] tl;
		logic [3:0] pan_l;
		logic [3:0] pan_r;
		logic [3:0] key;
		logic [7:0] samples;
	} row_t;

	localparam int NUM_ROWS = 4;

	logic clk;
	logic rst_n;
	logic [7:0] din;
	logic [1:0] addr;
	logic cs_n;
	logic wr_n;
	wire [7:0] dout;
	wire irq_n;
	wire fm_pkg::snd_t snd_left;
	wire fm_pkg::snd_t snd_right;
	wire snd_sample;

	row_t rows [NUM_ROWS];
	int cycles = 0;
	int cycle_limit = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	`include "fm_model.svh"

	fm_top dut0 (
		.clk(clk), .rst_n(rst_n), .din(din), .addr(addr), .cs_n(cs_n), .wr_n(wr_n),
		.dout(dout), .irq_n(irq_n), .snd_left(snd_left), .snd_right(snd_right),
		.snd_sample(snd_sample)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic check(input string name, input logic [11:0] exp, input logic [11:0] got);
		assert (got === exp) else begin
			$display("ERROR %s expected %h got %h", name, exp, got);
			test_errors++;
		end
	endtask

	task automatic expect_true(input string what, input logic cond);
		assert (cond) else begin
			$display("Failure: %s", what);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			$display("Test %s passed", name);
			tests_passed++;
		end else begin
			$display("Test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// One bus write, driven just after the edge
	task automatic bus_cycle(input logic a0, input logic [7:0] d);
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = {1'b0, a0};
		din = d;
		@(posedge clk);
		#1;
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic wait_idle;
		while (dout[7]) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		bus_cycle(1'b0, a);
		wait_idle();
		bus_cycle(1'b1, d);
	endtask

	task automatic read_status(output logic [7:0] s);
		cs_n = 1'b0;
		@(posedge clk);
		#1;
		s = dout;
		cs_n = 1'b1;
	endtask

	// Returns the cycles since the call
	task automatic wait_sample(output int gap);
		gap = 1;
		@(posedge clk);
		#1;
		while (!snd_sample) begin
			@(posedge clk);
			#1;
			gap++;
		end
	endtask

	task automatic wait_nonzero;
		int n;
		int tries;
		tries = 0;
		wait_sample(n);
		while (snd_left == 0 && snd_right == 0 && tries < 16) begin
			wait_sample(n);
			tries++;
		end
		expect_true("no audible sample after key on", snd_left != 0 || snd_right != 0);
	endtask

	task automatic set_channel(input int c, input logic [10:0] f, input logic [2:0] b,
		input logic [2:0] t, input logic pl, input logic pr);
		write_reg(fm_pkg::REG_FNUM_LO + 8'(c), f[7:0]);
		write_reg(fm_pkg::REG_FNUM_HI + 8'(c), {2'b00, b, f[10:8]});
		write_reg(fm_pkg::REG_TL + 8'(c), {5'd0, t});
		write_reg(fm_pkg::REG_PAN + 8'(c), {pl, pr, 6'd0});
	endtask

	task automatic key_off;
		int n;
		write_reg(fm_pkg::REG_KEY, 8'h00);
		// Up to two samples in flight still carry the old keys
		wait_sample(n);
		wait_sample(n);
		for (int i = 0; i < 4; i++) begin
			wait_sample(n);
			check("snd_left", 12'h000, snd_left);
			check("snd_right", 12'h000, snd_right);
		end
	endtask

	task automatic timer_flag(input int bit_no, input int max_samples);
		logic [7:0] st;
		int n;
		st = 8'h00;
		for (int i = 0; i < max_samples && !st[bit_no]; i++) begin
			wait_sample(n);
			read_status(st);
		end
		expect_true("timer flag did not set in time", st[bit_no]);
		check("irq_n", 12'h000, {11'd0, irq_n});
		// Clear the flag with load and enable off
		write_reg(fm_pkg::REG_TCTRL, 8'(1 << (bit_no + 4)));
		wait_idle();
		read_status(st);
		check("dout", 12'h000, {4'd0, st});
		check("irq_n", 12'h001, {11'd0, irq_n});
	endtask

	initial begin
		logic [7:0] st;
		logic [10:0] base;
		int n;

		rst_n = 1'b0;
		din = 8'h00;
		addr = 2'b00;
		cs_n = 1'b1;
		wr_n = 1'b1;
		void'($urandom(83532));

		// Columns block, tl, pan_l, pan_r, key, samples
		rows[0] = {3'd4, 3'd0, 4'hf, 4'hf, 4'h1, 8'd40};
		rows[1] = {3'd5, 3'd1, 4'h3, 4'h5, 4'hf, 8'd60};
		rows[2] = {3'd7, 3'd2, 4'ha, 4'h6, 4'h6, 8'd80};
		rows[3] = {3'd3, 3'd2, 4'hf, 4'h0, 4'h9, 8'd50};
		n = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			n += rows[r].samples + 8;
		// Rows take 18 writes each, the other tests about 20
		cycle_limit = (n + 80) * 4 + (NUM_ROWS * 18 + 20) * 20 + 500;

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		read_status(st);
		check("dout", 12'h000, {4'd0, st});
		check("irq_n", 12'h001, {11'd0, irq_n});
		check("snd_left", 12'h000, snd_left);
		check("snd_right", 12'h000, snd_right);
		wait_sample(n);
		for (int i = 0; i < 4; i++) begin
			wait_sample(n);
			check("snd_sample period", 12'd4, 12'(n));
		end
		end_test("reset state");

		base = 11'h400 | 11'($urandom() & 32'h1ff);
		set_channel(0, base, 3'd4, 3'd0, 1'b0, 1'b0);
		bus_cycle(1'b0, fm_pkg::REG_PAN);
		wait_idle();
		bus_cycle(1'b1, 8'h80);
		// Second write lands inside the busy window
		bus_cycle(1'b0, fm_pkg::REG_PAN);
		bus_cycle(1'b1, 8'h40);
		write_reg(fm_pkg::REG_KEY, 8'h01);
		wait_nonzero();
		check("snd_left", 12'(sample_sum(base, 4, 0, 4'h1, 4'h1, 1)), snd_left);
		check("snd_right", 12'h000, snd_right);
		key_off();
		end_test("dropped write");

		for (int r = 0; r < NUM_ROWS; r++) begin
			base = 11'h400 | 11'($urandom() & 32'h1ff);
			for (int c = 0; c < 4; c++)
				set_channel(c, ch_fnum(base, c), rows[r].block, rows[r].tl,
					rows[r].pan_l[c], rows[r].pan_r[c]);
			write_reg(fm_pkg::REG_KEY, {4'd0, rows[r].key});
			wait_nonzero();
			for (int k = 1; k <= rows[r].samples; k++) begin
				if (k > 1)
					wait_sample(n);
				check("snd_left", 12'(sample_sum(base, rows[r].block, rows[r].tl,
					rows[r].pan_l, rows[r].key, k)), snd_left);
				check("snd_right", 12'(sample_sum(base, rows[r].block, rows[r].tl,
					rows[r].pan_r, rows[r].key, k)), snd_right);
			end
			key_off();
			end_test($sformatf("tone row %0d", r));
		end

		write_reg(fm_pkg::REG_TA_HI, 8'(1020 >> 2));
		write_reg(fm_pkg::REG_TA_LO, 8'(1020 & 3));
		write_reg(fm_pkg::REG_TCTRL, 8'h05);
		timer_flag(0, 5);
		end_test("timer A");

		write_reg(fm_pkg::REG_TB, 8'd254);
		write_reg(fm_pkg::REG_TCTRL, 8'h0a);
		timer_flag(1, 3 * fm_pkg::TIMER_B_DIV);
		end_test("timer B");

		$display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
source/fm_pkg.sv
source/fm_regs.sv
source/fm_timers.sv
source/fm_phase.sv
source/fm_wave.sv
source/fm_mixer.sv
source/fm_top.sv
bench/fm_tb.sv

//--- source/fm_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module fm_mixer (
	input wire clk,
	input wire rst_n,
	input wire fm_pkg::wave_t wave,
	input wire wave_l,
	input wire wave_r,
	input wire wave_last,
	output fm_pkg::snd_t snd_left,
	output fm_pkg::snd_t snd_right,
	output logic snd_sample
);

	fm_pkg::snd_t sum_l;
	fm_pkg::snd_t sum_r;
	fm_pkg::snd_t add_l;
	fm_pkg::snd_t add_r;

	// Four 10-bit values cannot overflow 12 bits
	assign add_l = wave_l ? fm_pkg::snd_t'(wave) : '0;
	assign add_r = wave_r ? fm_pkg::snd_t'(wave) : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_l <= '0;
			sum_r <= '0;
			snd_left <= '0;
			snd_right <= '0;
			snd_sample <= 1'b0;
		end else begin
			snd_sample <= wave_last;
			if (wave_last) begin
				snd_left <= sum_l + add_l;
				snd_right <= sum_r + add_r;
				sum_l <= '0;
				sum_r <= '0;
			end else begin
				sum_l <= sum_l + add_l;
				sum_r <= sum_r + add_r;
			end
		end
	end

	// Slot counter upstream keeps strobes apart
	a_sample_gap: assert property (@(posedge clk) disable iff (!rst_n)
		snd_sample |=> !snd_sample);

endmodule

`default_nettype wire

//--- source/fm_phase.sv
`timescale 1ns/100ps
`default_nettype none

module fm_phase (
	input wire clk,
	input wire rst_n,
	input wire fm_pkg::ch_t slot,
	input wire last,
	input wire fm_pkg::fnum_t fnum,
	input wire fm_pkg::block_t block,
	input wire fm_pkg::tl_t tl,
	input wire pan_l,
	input wire pan_r,
	input wire key,
	output logic [9:0] phase_top,
	output fm_pkg::tl_t tl_q,
	output logic pan_l_q,
	output logic pan_r_q,
	output logic key_q,
	output logic last_q
);

	fm_pkg::phase_t acc [fm_pkg::NUM_CH];
	fm_pkg::phase_t inc;
	fm_pkg::phase_t sum;

	// Octave scales fnum, then halved
	assign inc = (fm_pkg::phase_t'(fnum) << block) >> 1;
	assign sum = acc[slot] + inc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < fm_pkg::NUM_CH; i++)
				acc[i] <= '0;
			key_q <= 1'b0;
			last_q <= 1'b0;
			pan_l_q <= 1'b0;
			pan_r_q <= 1'b0;
		end else begin
			// Keyed-off channel stays parked at zero
			acc[slot] <= key ? sum : '0;
			key_q <= key;
			last_q <= last;
			pan_l_q <= pan_l;
			pan_r_q <= pan_r;
		end
	end

	always_ff @(posedge clk) begin
		phase_top <= key ? sum[19:10] : '0;
		tl_q <= tl;
	end

endmodule

`default_nettype wire

//--- source/fm_pkg.sv
`default_nettype none

package fm_pkg;

	// Channels share one datapath, one slot per clock
	localparam int NUM_CH = 4;
	// Cycles the chip refuses data after a register write
	localparam int BUSY_CYCLES = 8;
	// Samples per timer B count
	localparam int TIMER_B_DIV = 16;

	// Register map
	localparam logic [7:0] REG_TA_HI = 8'h24;
	localparam logic [7:0] REG_TA_LO = 8'h25;
	localparam logic [7:0] REG_TB = 8'h26;
	localparam logic [7:0] REG_TCTRL = 8'h27;
	localparam logic [7:0] REG_KEY = 8'h28;
	// Per-channel blocks, channel number in the low two bits
	localparam logic [7:0] REG_FNUM_LO = 8'hA0;
	localparam logic [7:0] REG_FNUM_HI = 8'hA4;
	localparam logic [7:0] REG_TL = 8'h40;
	localparam logic [7:0] REG_PAN = 8'hB4;

	typedef logic [1:0] ch_t;
	typedef logic [10:0] fnum_t;
	typedef logic [2:0] block_t;
	typedef logic [19:0] phase_t;
	typedef logic signed [9:0] wave_t;
	typedef logic signed [11:0] snd_t;
	typedef logic [2:0] tl_t;
	typedef logic [9:0] timer_a_t;
	typedef logic [7:0] timer_b_t;

endpackage

`default_nettype wire

//--- source/fm_regs.sv
`timescale 1ns/100ps
`default_nettype none

module fm_regs (
	input wire clk,
	input wire rst_n,
	input wire [7:0] din,
	input wire addr,
	input wire cs_n,
	input wire wr_n,
	output logic busy,
	output fm_pkg::ch_t slot,
	output logic last,
	output fm_pkg::fnum_t fnum,
	output fm_pkg::block_t block,
	output fm_pkg::tl_t tl,
	output logic pan_l,
	output logic pan_r,
	output logic key,
	output logic sample_tick,
	output fm_pkg::timer_a_t timer_a,
	output fm_pkg::timer_b_t timer_b,
	output logic tctrl_wr,
	output logic load_a,
	output logic load_b,
	output logic en_a,
	output logic en_b,
	output logic clr_a,
	output logic clr_b
);

	typedef enum logic {IDLE, ADDR_HELD} bus_state_e;

	localparam int BUSY_W = $clog2(fm_pkg::BUSY_CYCLES + 1);

	bus_state_e state;
	logic [7:0] addr_q;
	logic [BUSY_W-1:0] busy_cnt;
	logic bus_wr;
	logic data_acc;
	fm_pkg::ch_t wr_ch;

	logic [7:0] fnum_lo [fm_pkg::NUM_CH];
	logic [2:0] fnum_hi [fm_pkg::NUM_CH];
	fm_pkg::block_t block_r [fm_pkg::NUM_CH];
	fm_pkg::tl_t tl_r [fm_pkg::NUM_CH];
	logic [fm_pkg::NUM_CH-1:0] pan_l_r;
	logic [fm_pkg::NUM_CH-1:0] pan_r_r;
	logic [fm_pkg::NUM_CH-1:0] key_r;
	logic [fm_pkg::NUM_CH-1:0] key_work;
	logic [7:0] ta_hi;
	logic [1:0] ta_lo;
	fm_pkg::timer_b_t tb_r;
	logic [5:0] tctrl;

	assign bus_wr = !cs_n && !wr_n;
	// Data needs a latched address and an idle chip
	assign data_acc = bus_wr && addr && !busy && (state == ADDR_HELD);
	assign wr_ch = fm_pkg::ch_t'(addr_q[1:0]);
	assign busy = (busy_cnt != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			addr_q <= '0;
			busy_cnt <= '0;
			tctrl_wr <= 1'b0;
		end else begin
			if (bus_wr && !addr) begin
				state <= ADDR_HELD;
				addr_q <= din;
			end
			if (data_acc)
				busy_cnt <= BUSY_W'(fm_pkg::BUSY_CYCLES);
			else if (busy)
				busy_cnt <= busy_cnt - 1'b1;
			tctrl_wr <= data_acc && (addr_q == fm_pkg::REG_TCTRL);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < fm_pkg::NUM_CH; i++) begin
				fnum_lo[i] <= '0;
				fnum_hi[i] <= '0;
				block_r[i] <= '0;
				tl_r[i] <= '0;
			end
			pan_l_r <= '0;
			pan_r_r <= '0;
			key_r <= '0;
			ta_hi <= '0;
			ta_lo <= '0;
			tb_r <= '0;
			tctrl <= '0;
		end else if (data_acc) begin
			case (addr_q)
				fm_pkg::REG_TA_HI: ta_hi <= din;
				fm_pkg::REG_TA_LO: ta_lo <= din[1:0];
				fm_pkg::REG_TB: tb_r <= din;
				fm_pkg::REG_TCTRL: tctrl <= din[5:0];
				fm_pkg::REG_KEY: key_r <= din[fm_pkg::NUM_CH-1:0];
				default: ;
			endcase
			// Channel blocks are four apart
			case (addr_q[7:2])
				fm_pkg::REG_FNUM_LO[7:2]: fnum_lo[wr_ch] <= din;
				fm_pkg::REG_FNUM_HI[7:2]: begin
					fnum_hi[wr_ch] <= din[2:0];
					block_r[wr_ch] <= din[5:3];
				end
				fm_pkg::REG_TL[7:2]: tl_r[wr_ch] <= din[2:0];
				fm_pkg::REG_PAN[7:2]: begin
					pan_r_r[wr_ch] <= din[6];
					pan_l_r[wr_ch] <= din[7];
				end
				default: ;
			endcase
		end
	end

	// Slot counter, key changes land on a sample boundary
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= '0;
			key_work <= '0;
		end else begin
			slot <= slot + 1'b1;
			if (sample_tick)
				key_work <= key_r;
		end
	end

	assign last = (slot == fm_pkg::ch_t'(fm_pkg::NUM_CH - 1));
	assign sample_tick = last;

	assign fnum = {fnum_hi[slot], fnum_lo[slot]};
	assign block = block_r[slot];
	assign tl = tl_r[slot];
	assign pan_l = pan_l_r[slot];
	assign pan_r = pan_r_r[slot];
	assign key = key_work[slot];

	assign timer_a = {ta_hi, ta_lo};
	assign timer_b = tb_r;
	assign load_a = tctrl[0];
	assign load_b = tctrl[1];
	assign en_a = tctrl[2];
	assign en_b = tctrl[3];
	assign clr_a = tctrl[4];
	assign clr_b = tctrl[5];

	// No second write gets in during the busy window
	a_busy_drop: assert property (@(posedge clk) disable iff (!rst_n)
		data_acc |=> !data_acc [*fm_pkg::BUSY_CYCLES]);

endmodule

`default_nettype wire

//--- source/fm_timers.sv
`timescale 1ns/100ps
`default_nettype none

module fm_timers (
	input wire clk,
	input wire rst_n,
	input wire sample_tick,
	input wire fm_pkg::timer_a_t timer_a,
	input wire fm_pkg::timer_b_t timer_b,
	input wire tctrl_wr,
	input wire load_a,
	input wire load_b,
	input wire en_a,
	input wire en_b,
	input wire clr_a,
	input wire clr_b,
	output logic flag_a,
	output logic flag_b,
	output logic irq_n
);

	localparam int PRESC_W = $clog2(fm_pkg::TIMER_B_DIV);

	fm_pkg::timer_a_t cnt_a;
	fm_pkg::timer_b_t cnt_b;
	logic [PRESC_W-1:0] presc;
	logic b_tick;
	logic ovf_a;
	logic ovf_b;
	logic flag_a_nxt;
	logic flag_b_nxt;

	assign b_tick = sample_tick && (presc == PRESC_W'(fm_pkg::TIMER_B_DIV - 1));
	assign ovf_a = load_a && sample_tick && (cnt_a == '1);
	assign ovf_b = load_b && b_tick && (cnt_b == '1);

	// Stopped timers sit at their load value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_a <= '0;
			cnt_b <= '0;
			presc <= '0;
		end else begin
			if (!load_a)
				cnt_a <= timer_a;
			else if (sample_tick)
				cnt_a <= ovf_a ? timer_a : cnt_a + 1'b1;
			if (!load_b) begin
				cnt_b <= timer_b;
				presc <= '0;
			end else if (sample_tick) begin
				presc <= presc + 1'b1;
				if (b_tick)
					cnt_b <= ovf_b ? timer_b : cnt_b + 1'b1;
			end
		end
	end

	// Overflow wins over a clear in the same cycle
	always_comb begin
		flag_a_nxt = flag_a;
		flag_b_nxt = flag_b;
		if (tctrl_wr && clr_a)
			flag_a_nxt = 1'b0;
		if (tctrl_wr && clr_b)
			flag_b_nxt = 1'b0;
		if (ovf_a && en_a)
			flag_a_nxt = 1'b1;
		if (ovf_b && en_b)
			flag_b_nxt = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
			irq_n <= 1'b1;
		end else begin
			flag_a <= flag_a_nxt;
			flag_b <= flag_b_nxt;
			irq_n <= !(flag_a_nxt || flag_b_nxt);
		end
	end

	a_irq_flags: assert property (@(posedge clk) disable iff (!rst_n)
		irq_n == !(flag_a || flag_b));

endmodule

`default_nettype wire

//--- source/fm_top.sv
`timescale 1ns/100ps
`default_nettype none

module fm_top (
	input wire clk,
	input wire rst_n,
	input wire [7:0] din,
	input wire [1:0] addr,
	input wire cs_n,
	input wire wr_n,
	output logic [7:0] dout,
	output logic irq_n,
	output fm_pkg::snd_t snd_left,
	output fm_pkg::snd_t snd_right,
	output logic snd_sample
);

	logic busy, flag_a, flag_b;
	fm_pkg::ch_t slot;
	logic last, pan_l, pan_r, key, sample_tick;
	fm_pkg::fnum_t fnum;
	fm_pkg::block_t block;
	fm_pkg::tl_t tl;
	fm_pkg::timer_a_t timer_a;
	fm_pkg::timer_b_t timer_b;
	logic tctrl_wr, load_a, load_b, en_a, en_b, clr_a, clr_b;
	logic [9:0] phase_top;
	fm_pkg::tl_t tl_q;
	logic pan_l_q, pan_r_q, key_q, last_q;
	fm_pkg::wave_t wave;
	logic wave_l, wave_r, wave_last;

	// Status byte
	assign dout = {busy, 5'd0, flag_b, flag_a};

	fm_regs u_regs (
		.clk(clk), .rst_n(rst_n), .din(din), .addr(addr[0]), .cs_n(cs_n), .wr_n(wr_n),
		.busy(busy), .slot(slot), .last(last), .fnum(fnum), .block(block), .tl(tl),
		.pan_l(pan_l), .pan_r(pan_r), .key(key), .sample_tick(sample_tick),
		.timer_a(timer_a), .timer_b(timer_b), .tctrl_wr(tctrl_wr),
		.load_a(load_a), .load_b(load_b), .en_a(en_a), .en_b(en_b),
		.clr_a(clr_a), .clr_b(clr_b)
	);

	fm_timers u_timers (
		.clk(clk), .rst_n(rst_n), .sample_tick(sample_tick),
		.timer_a(timer_a), .timer_b(timer_b), .tctrl_wr(tctrl_wr),
		.load_a(load_a), .load_b(load_b), .en_a(en_a), .en_b(en_b),
		.clr_a(clr_a), .clr_b(clr_b),
		.flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
	);

	fm_phase u_phase (
		.clk(clk), .rst_n(rst_n), .slot(slot), .last(last), .fnum(fnum),
		.block(block), .tl(tl), .pan_l(pan_l), .pan_r(pan_r), .key(key),
		.phase_top(phase_top), .tl_q(tl_q), .pan_l_q(pan_l_q), .pan_r_q(pan_r_q),
		.key_q(key_q), .last_q(last_q)
	);

	fm_wave u_wave (
		.clk(clk), .rst_n(rst_n), .phase_top(phase_top), .tl_q(tl_q),
		.pan_l_q(pan_l_q), .pan_r_q(pan_r_q), .key_q(key_q), .last_q(last_q),
		.wave(wave), .wave_l(wave_l), .wave_r(wave_r), .wave_last(wave_last)
	);

	fm_mixer u_mixer (
		.clk(clk), .rst_n(rst_n), .wave(wave), .wave_l(wave_l), .wave_r(wave_r),
		.wave_last(wave_last), .snd_left(snd_left), .snd_right(snd_right),
		.snd_sample(snd_sample)
	);

endmodule

`default_nettype wire

//--- source/fm_wave.sv
`timescale 1ns/100ps
`default_nettype none

module fm_wave (
	input wire clk,
	input wire rst_n,
	input wire [9:0] phase_top,
	input wire fm_pkg::tl_t tl_q,
	input wire pan_l_q,
	input wire pan_r_q,
	input wire key_q,
	input wire last_q,
	output fm_pkg::wave_t wave,
	output logic wave_l,
	output logic wave_r,
	output logic wave_last
);

	fm_pkg::wave_t tri_v;
	fm_pkg::wave_t att_v;

	// Triangle, peaks held for two steps at +255 and -256
	always_comb begin
		case (phase_top[9:8])
			2'b01, 2'b10: tri_v = fm_pkg::wave_t'(10'd511 - phase_top);
			default: tri_v = fm_pkg::wave_t'(phase_top);
		endcase
	end

	assign att_v = tri_v >>> tl_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wave_l <= 1'b0;
			wave_r <= 1'b0;
			wave_last <= 1'b0;
		end else begin
			wave_l <= pan_l_q;
			wave_r <= pan_r_q;
			wave_last <= last_q;
		end
	end

	always_ff @(posedge clk)
		wave <= key_q ? att_v : '0;

endmodule

`default_nettype wire
